// ==== Makefile ====
# Verilator lint and simulation of the direct-mapped cache
VERILATOR ?= verilator
FILELIST  ?= vlog.f
TB_TOP    ?= tb_cache
RTL_TOP   ?= direct_mapped_cache
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert --timescale 1ns/100ps
RTL_SRCS  ?= common/cache_geom_pkg.sv common/cache_bus_pkg.sv cache/cache_array.sv \
             cache/cache_ctrl.sv verilog/direct_mapped_cache.sv
PASS_MSG  ?= *** PASSED ***

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		--Mdir $(OBJ_DIR) -o V$(TB_TOP)
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; echo "$$out"; \
		echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

// ==== cache/cache_array.sv ====
// tag, valid and data storage of the cache; combinational lookup, synchronous fill and merge
`default_nettype none

module cache_array (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire cache_geom_pkg::word_addr_t addr,      // current processor address
    input  wire cache_geom_pkg::word_t  wdata,         // word for a merge
    input  wire cache_geom_pkg::line_t  mem_rdata,     // line for a fill
    input  wire                        fill_en,
    input  wire                        merge_en,
    output logic                       hit,
    output cache_geom_pkg::line_t      line,
    output cache_geom_pkg::word_t      rdata
);

    // ------------------------------
    // storage
    // ------------------------------
    logic [cache_geom_pkg::num_lines-1:0] valid_q;
    cache_geom_pkg::tag_t                 tag_q  [cache_geom_pkg::num_lines];
    cache_geom_pkg::line_t                data_q [cache_geom_pkg::num_lines];

    cache_geom_pkg::index_t  idx;
    cache_geom_pkg::offset_t off;

    assign idx = addr.index;
    assign off = addr.offset;

    // ------------------------------
    // lookup
    // ------------------------------
    // the only tag compare in the cache
    assign hit  = valid_q[idx] && (tag_q[idx] == addr.tag);
    assign line = data_q[idx];

    always_comb begin
        rdata = line[off * cache_geom_pkg::word_bits +: cache_geom_pkg::word_bits];
    end

    // ------------------------------
    // update
    // ------------------------------
    // valid bits only, lines start out invalid
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else if (fill_en) begin
            valid_q[idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_en) begin
            tag_q[idx]  <= addr.tag;
            data_q[idx] <= mem_rdata;       // whole line from memory
        end else if (merge_en) begin
            // replace the addressed word, keep the other three
            data_q[idx][off * cache_geom_pkg::word_bits +: cache_geom_pkg::word_bits] <= wdata;
        end
    end

    // ------------------------------
    // checks
    // ------------------------------
    // fill and merge come from different FSM states
    a_fill_merge_excl : assert property (
        @(posedge clk) disable iff (!rst_n)
        !(fill_en && merge_en)
    ) else $error("cache_array: fill_en and merge_en high together");

endmodule

`default_nettype wire

// ==== cache/cache_ctrl.sv ====
// cache controller FSM; handles misses, line fills and write-through, drives stall and memory
`default_nettype none

module cache_ctrl (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire cache_bus_pkg::proc_req_t req,
    input  wire                        hit,         // from the array
    input  wire cache_geom_pkg::line_t  line,        // indexed line, source of write-back data
    input  wire                        mem_ready,
    output logic                       proc_stall,
    output logic                       fill_en,
    output logic                       merge_en,
    output cache_bus_pkg::mem_req_t    mem
);

    cache_bus_pkg::cache_state_t state_q, state_d;

    // memory request registers
    logic                       mem_rd_q, mem_rd_d;
    logic                       mem_wr_q, mem_wr_d;
    cache_geom_pkg::line_addr_t mem_addr_q;
    cache_geom_pkg::line_t      mem_wdata_q;

    logic load_addr;    // capture line address from req
    logic load_wdata;   // capture indexed line for write-back

    // ------------------------------
    // next state and outputs
    // ------------------------------
    always_comb begin
        state_d    = state_q;
        proc_stall = 1'b1;
        fill_en    = 1'b0;
        merge_en   = 1'b0;
        mem_rd_d   = mem_rd_q;
        mem_wr_d   = mem_wr_q;
        load_addr  = 1'b0;
        load_wdata = 1'b0;

        case (state_q)
            cache_bus_pkg::idle: begin
                if (req.read) begin
                    if (hit) begin
                        proc_stall = 1'b0;          // data straight from the array
                    end else begin
                        state_d   = cache_bus_pkg::fill_read;
                        mem_rd_d  = 1'b1;
                        load_addr = 1'b1;
                    end
                end else if (req.write) begin
                    if (hit) begin
                        state_d = cache_bus_pkg::merge;
                    end else begin
                        // write-allocate, fetch the line first
                        state_d   = cache_bus_pkg::fill_write;
                        mem_rd_d  = 1'b1;
                        load_addr = 1'b1;
                    end
                end else begin
                    proc_stall = 1'b0;
                end
            end

            cache_bus_pkg::fill_read: begin
                if (mem_ready) begin
                    fill_en  = 1'b1;
                    mem_rd_d = 1'b0;
                    state_d  = cache_bus_pkg::idle;  // hit follows next cycle
                end
            end

            cache_bus_pkg::fill_write: begin
                if (mem_ready) begin
                    fill_en  = 1'b1;
                    mem_rd_d = 1'b0;
                    state_d  = cache_bus_pkg::merge;
                end
            end

            cache_bus_pkg::merge: begin
                merge_en = 1'b1;
                state_d  = cache_bus_pkg::write_back;
            end

            cache_bus_pkg::write_back: begin
                if (!mem_wr_q) begin
                    // array holds the merged line by now
                    mem_wr_d   = 1'b1;
                    load_addr  = 1'b1;
                    load_wdata = 1'b1;
                end else if (mem_ready) begin
                    mem_wr_d   = 1'b0;
                    proc_stall = 1'b0;
                    state_d    = cache_bus_pkg::idle;
                end
            end

            default: begin
                state_d = cache_bus_pkg::idle;
            end
        endcase
    end

    // ------------------------------
    // registers
    // ------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q  <= cache_bus_pkg::idle;
            mem_rd_q <= 1'b0;
            mem_wr_q <= 1'b0;
        end else begin
            state_q  <= state_d;
            mem_rd_q <= mem_rd_d;
            mem_wr_q <= mem_wr_d;
        end
    end

    // payload, only meaningful while read or write is up
    always_ff @(posedge clk) begin
        if (load_addr) begin
            mem_addr_q <= '{tag: req.addr.tag, index: req.addr.index};
        end
        if (load_wdata) begin
            mem_wdata_q <= line;
        end
    end

    assign mem = '{read: mem_rd_q, write: mem_wr_q, addr: mem_addr_q, wdata: mem_wdata_q};

    // ------------------------------
    // checks
    // ------------------------------
    a_req_excl : assert property (
        @(posedge clk) disable iff (!rst_n)
        !(req.read && req.write)
    ) else $error("cache_ctrl: read and write requested together");

    a_ready_with_req : assert property (
        @(posedge clk) disable iff (!rst_n)
        mem_ready |-> (mem.read || mem.write)
    ) else $error("cache_ctrl: mem_ready without a memory request");

    // request held unchanged until memory answers
    a_req_stable : assert property (
        @(posedge clk) disable iff (!rst_n)
        ((mem.read || mem.write) && !mem_ready) |=> $stable(mem)
    ) else $error("cache_ctrl: memory request changed while waiting");

endmodule

`default_nettype wire

// ==== common/cache_bus_pkg.sv ====
// processor and memory request structs plus controller states, shared by cache RTL and testbench
`default_nettype none

package cache_bus_pkg;

    // ------------------------------
    // processor side
    // ------------------------------
    // read and write are levels, at most one of them high
    typedef struct packed {
        logic                     read;
        logic                     write;
        cache_geom_pkg::word_addr_t addr;
        cache_geom_pkg::word_t      wdata;
    } proc_req_t;

    // ------------------------------
    // memory side
    // ------------------------------
    // held by the cache until memory answers with a one-cycle ready
    typedef struct packed {
        logic                     read;
        logic                     write;
        cache_geom_pkg::line_addr_t addr;
        cache_geom_pkg::line_t      wdata;
    } mem_req_t;

    // ------------------------------
    // controller FSM
    // ------------------------------
    typedef enum logic [2:0] {
        idle       = 3'd0,  // serve hits, decide on misses
        fill_read  = 3'd1,  // line fetch for a read miss
        fill_write = 3'd2,  // line fetch for a write miss
        merge      = 3'd3,  // one cycle, new word into the line
        write_back = 3'd4   // write-through of the merged line
    } cache_state_t;

endpackage

`default_nettype wire

// ==== common/cache_geom_pkg.sv ====
// cache geometry and address field types, referenced by scoped name from RTL and testbench
`default_nettype none

package cache_geom_pkg;

    // ------------------------------
    // sizes
    // ------------------------------
    localparam int word_bits   = 32;                      // processor word
    localparam int line_words  = 4;
    localparam int line_bits   = word_bits * line_words;  // 128
    localparam int offset_bits = $clog2(line_words);      // word within a line
    localparam int index_bits  = 3;
    localparam int num_lines   = 1 << index_bits;         // direct mapped, 8 entries
    localparam int tag_bits    = 25;                      // 30-bit word address minus index and offset

    // ------------------------------
    // address fields
    // ------------------------------
    typedef logic [tag_bits-1:0]    tag_t;
    typedef logic [index_bits-1:0]  index_t;
    typedef logic [offset_bits-1:0] offset_t;

    typedef logic [word_bits-1:0]   word_t;
    typedef logic [line_bits-1:0]   line_t;

    // 30-bit word address, tag in the upper bits
    typedef struct packed {
        tag_t    tag;
        index_t  index;
        offset_t offset;
    } word_addr_t;

    // 28-bit line address as seen by memory
    typedef struct packed {
        tag_t   tag;
        index_t index;
    } line_addr_t;

endpackage

`default_nettype wire

// ==== verification/cache_checker.sv ====
// testbench checker; watches the cache ports, keeps a shadow memory and tag model, counts results
`default_nettype none

module cache_checker (
    input  wire                           clk,
    input  wire                           rst_n,
    input  wire cache_bus_pkg::proc_req_t req,
    input  wire                           proc_stall,
    input  wire cache_geom_pkg::word_t    rdata,
    input  wire cache_bus_pkg::mem_req_t  mem,
    input  wire                           mem_ready,
    output int                            passed,
    output int                            failed
);
    timeunit 1ns;
    timeprecision 100ps;

    cache_geom_pkg::word_t                shadow [int unsigned];  // words written so far
    logic [cache_geom_pkg::num_lines-1:0] tag_valid;
    cache_geom_pkg::tag_t                 tag_model [cache_geom_pkg::num_lines];
    logic                                 busy;      // request in progress
    logic                                 exp_miss;
    logic                                 req_ok;
    int                                   rd_seen;
    int                                   wr_seen;

    function automatic cache_geom_pkg::word_t expected_word(input cache_geom_pkg::word_addr_t a);
        if (shadow.exists(32'(a))) begin
            return shadow[32'(a)];
        end
        return {2'b00, a};                  // untouched memory holds its own address
    endfunction

    function automatic cache_geom_pkg::line_t expected_line(input cache_geom_pkg::line_addr_t la);
        cache_geom_pkg::line_t l;
        for (int o = 0; o < cache_geom_pkg::line_words; o++) begin
            l[o*cache_geom_pkg::word_bits +: cache_geom_pkg::word_bits] =
                expected_word({la, cache_geom_pkg::offset_t'(o)});
        end
        return l;
    endfunction

    task automatic report_mismatch(input string msg);
        $display("Fail at %0d ns: %s", $time, msg);
        req_ok = 1'b0;
    endtask

    task automatic finish_request();
        if (req.read && rdata !== expected_word(req.addr)) begin
            report_mismatch($sformatf("read %h returned %h, expected %h",
                                      req.addr, rdata, expected_word(req.addr)));
        end
        if (rd_seen != (exp_miss ? 1 : 0) || wr_seen != (req.write ? 1 : 0)) begin
            report_mismatch($sformatf("%0d memory reads, %0d writes for %h, expected %0d, %0d",
                                      rd_seen, wr_seen, req.addr, exp_miss ? 1 : 0,
                                      req.write ? 1 : 0));
        end
        tag_valid[req.addr.index] = 1'b1;   // allocate on read and write
        tag_model[req.addr.index] = req.addr.tag;
        busy = 1'b0;
        if (req_ok) passed++;
        else failed++;
        $display("%s %h  mem reads %0d  mem writes %0d  %s", req.write ? "write" : "read ",
                 req.addr, rd_seen, wr_seen, req_ok ? "ok" : "mismatch");
    endtask

    // ------------------------------
    // sampled mid-cycle, all stable
    // ------------------------------
    always @(negedge clk) begin
        if (!rst_n) begin
            passed    = 0;
            failed    = 0;
            busy      = 1'b0;
            tag_valid = '0;
            shadow.delete();
        end else if (!req.read && !req.write) begin
            busy = 1'b0;
            if (proc_stall || mem.read || mem.write) begin
                report_mismatch("stall or memory request raised with no request");
                failed++;
            end
        end else begin
            if (!busy) begin                // first cycle of a new request
                busy     = 1'b1;
                req_ok   = 1'b1;
                rd_seen  = 0;
                wr_seen  = 0;
                exp_miss = !(tag_valid[req.addr.index] &&
                             tag_model[req.addr.index] == req.addr.tag);
                if (req.write) shadow[32'(req.addr)] = req.wdata;
                if (req.read && !exp_miss && proc_stall)
                    report_mismatch($sformatf("read hit at %h stalled", req.addr));
            end
            if (mem_ready && (mem.addr.tag != req.addr.tag || mem.addr.index != req.addr.index))
                report_mismatch($sformatf("memory line %h, request at %h", mem.addr, req.addr));
            if (mem_ready && mem.read) rd_seen++;
            if (mem_ready && mem.write) begin
                wr_seen++;
                if (mem.wdata !== expected_line(mem.addr))
                    report_mismatch($sformatf("write-back %h, expected %h",
                                              mem.wdata, expected_line(mem.addr)));
            end
            if (!proc_stall) finish_request();
        end
    end
endmodule

`default_nettype wire

// ==== verification/cache_patterns.txt ====
# op word_addr wdata : R read, W write, address and data in hex
# wdata is ignored on reads, addresses stay below 0x100
R 00000004 00000000
R 00000006 00000000
R 00000004 00000000
R 00000024 00000000
R 00000004 00000000
W 00000005 a5a50005
R 00000005 00000000
R 00000007 00000000
W 00000049 c3c30049
R 0000004b 00000000
R 00000049 00000000
R 00000029 00000000
R 00000049 00000000
R 00000048 00000000
W 00000024 11110024
W 00000025 22220025
R 00000024 00000000
R 00000005 00000000
W 000000fc 333300fc
R 000000fd 00000000
W 000000fd 444400fd
R 000000dc 00000000
R 000000fc 00000000
W 00000000 55550000
R 00000001 00000000
R 00000000 00000000
W 000000e3 666600e3
R 000000e3 00000000
R 00000025 00000000

// ==== verification/clock_gen.sv ====
// testbench clock and reset source; 100 ns clock, reset held low for the first 4 cycles
`default_nettype none

module clock_gen (
    output logic clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int half_period  = 50;
    localparam int reset_cycles = 4;
    localparam int drive_delay  = 10;   // same offset as the stimulus

    initial begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        #drive_delay;
        rst_n = 1'b1;
    end
endmodule

`default_nettype wire

// ==== verification/tb_cache.sv ====
// testbench top; reads request patterns, drives the cache, models a slow line memory, reports
`default_nettype none

module tb_cache;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int drive_delay = 10;    // after the rising edge
    localparam int wait_limit  = 40;    // cycles per wait loop
    localparam int mem_lines_n = 64;

    logic                     clk;
    logic                     rst_n;
    cache_bus_pkg::proc_req_t req;
    logic                     proc_stall;
    cache_geom_pkg::word_t    rdata;
    cache_bus_pkg::mem_req_t  mem;
    cache_geom_pkg::line_t    mem_rdata;
    logic                     mem_ready;
    int                       passed;
    int                       failed;
    int                       issued;
    logic                     aborted;
    cache_geom_pkg::line_t    mem_lines [mem_lines_n];
    logic [31:0]              lfsr_state;

    clock_gen u_clock (.clk(clk), .rst_n(rst_n));

    direct_mapped_cache UUT (
        .clk(clk), .rst_n(rst_n), .req(req), .proc_stall(proc_stall), .rdata(rdata),
        .mem(mem), .mem_rdata(mem_rdata), .mem_ready(mem_ready)
    );

    cache_checker u_checker (
        .clk(clk), .rst_n(rst_n), .req(req), .proc_stall(proc_stall), .rdata(rdata),
        .mem(mem), .mem_ready(mem_ready), .passed(passed), .failed(failed)
    );

    // galois form, taps x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic draw_latency(output int lat);
        logic [1:0] bits;
        bits[0]    = lfsr_state[0];
        lfsr_state = lfsr_step(lfsr_state);
        bits[1]    = lfsr_state[0];
        lfsr_state = lfsr_step(lfsr_state);
        lat = int'(bits) + 1;           // 1 to 4 cycles
    endtask

    // ------------------------------
    // line memory, ready after a random latency
    // ------------------------------
    initial begin
        int wait_left;
        mem_ready  = 1'b0;
        mem_rdata  = '0;
        lfsr_state = 32'h3599;
        wait_left  = 0;
        for (int w = 0; w < mem_lines_n * cache_geom_pkg::line_words; w++) begin
            mem_lines[w / 4][(w % 4) * 32 +: 32] = 32'(w);
        end
        forever begin
            @(posedge clk);
            #drive_delay;
            if (mem_ready) begin
                mem_ready = 1'b0;       // cache dropped its request on that edge
            end else if (mem.read || mem.write) begin
                if (wait_left == 0) draw_latency(wait_left);
                if (wait_left == 1) begin
                    mem_ready = 1'b1;
                    if (mem.read) mem_rdata = mem_lines[mem.addr[5:0]];
                    else mem_lines[mem.addr[5:0]] = mem.wdata;
                end
                wait_left--;
            end
        end
    end

    task automatic run_request(input logic is_write, input cache_geom_pkg::word_addr_t addr,
                               input cache_geom_pkg::word_t data);
        int waited;
        @(posedge clk);
        #drive_delay;
        req    = '{read: !is_write, write: is_write, addr: addr, wdata: data};
        waited = 0;
        @(negedge clk);
        while (proc_stall && waited < wait_limit) begin
            @(negedge clk);
            waited++;
        end
        if (proc_stall) begin
            $display("no answer from the cache within %0d cycles at address %h", wait_limit, addr);
            aborted = 1'b1;
        end
        @(posedge clk);
        #drive_delay;
        req = '0;                       // one idle cycle before the next one
    endtask

    initial begin
        int          fd;
        int          waited;
        string       text;
        byte         op;
        logic [31:0] addr_val;
        logic [31:0] data_val;
        req     = '0;
        issued  = 0;
        aborted = 1'b0;
        waited  = 0;
        while (rst_n !== 1'b1 && waited < wait_limit) begin
            @(posedge clk);
            waited++;
        end
        if (rst_n !== 1'b1) begin
            $display("reset was never released");
            aborted = 1'b1;
        end
        repeat (3) @(posedge clk);      // idle after reset, checker watches stall
        fd = $fopen("verification/cache_patterns.txt", "r");
        if (fd == 0) begin
            $display("cannot open the pattern file");
            aborted = 1'b1;
        end
        while (fd != 0 && !aborted && $fgets(text, fd) > 0) begin
            if (text.len() < 5 || text[0] == "#") continue;
            if ($sscanf(text, "%c %h %h", op, addr_val, data_val) != 3 ||
                (op != "R" && op != "W")) begin
                $display("unreadable pattern line: %s", text);
                aborted = 1'b1;
            end else begin
                run_request(op == "W", addr_val[29:0], data_val);
                issued++;
            end
        end
        if (fd != 0) $fclose(fd);
        repeat (4) @(posedge clk);
        $display("requests %0d, passed %0d, failed %0d", issued, passed, failed);
        if (!aborted && failed == 0 && passed == issued) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end
endmodule

`default_nettype wire

// ==== verilog/direct_mapped_cache.sv ====
// top level of the direct-mapped write-through cache, joins the controller FSM and the array
`default_nettype none

module direct_mapped_cache (
    input  wire                        clk,
    input  wire                        rst_n,
    // processor side
    input  wire cache_bus_pkg::proc_req_t req,
    output logic                       proc_stall,
    output cache_geom_pkg::word_t      rdata,       // valid on a read with stall low
    // memory side
    output cache_bus_pkg::mem_req_t    mem,
    input  wire cache_geom_pkg::line_t  mem_rdata,
    input  wire                        mem_ready
);

    // ------------------------------
    // controller to array
    // ------------------------------
    logic                  hit;
    cache_geom_pkg::line_t line;
    logic                  fill_en;
    logic                  merge_en;

    cache_ctrl u_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (req),
        .hit        (hit),
        .line       (line),
        .mem_ready  (mem_ready),
        .proc_stall (proc_stall),
        .fill_en    (fill_en),
        .merge_en   (merge_en),
        .mem        (mem)
    );

    cache_array u_array (
        .clk       (clk),
        .rst_n     (rst_n),
        .addr      (req.addr),
        .wdata     (req.wdata),
        .mem_rdata (mem_rdata),
        .fill_en   (fill_en),
        .merge_en  (merge_en),
        .hit       (hit),
        .line      (line),
        .rdata     (rdata)
    );

endmodule

`default_nettype wire

// ==== vlog.f ====
common/cache_geom_pkg.sv
common/cache_bus_pkg.sv
cache/cache_array.sv
cache/cache_ctrl.sv
verilog/direct_mapped_cache.sv
verification/clock_gen.sv
verification/cache_checker.sv
verification/tb_cache.sv
